/* all.f */
+incdir+include
source/dec_pkg.sv
source/fetch_port.sv
source/inst_decoder.sv
source/operand_select.sv
source/branch_unit.sv
source/issue_port.sv
source/dec_top.sv
dv/dec_tb.sv

/* dv/dec_tb.sv */
`timescale 1ns/1ns
`include "dec_consts.svh"

module dec_tb import dec_pkg::*; ();

    localparam int TIMEOUT = 200;

    logic         clk;
    logic         rst;
    logic         fetch_req;
    fetch_t       fetch_in;
    logic         fetch_ack;
    raddr_t [1:0] rf_rd;
    word_t  [1:0] rf_data;
    reg_write_t   fwd_ex;
    reg_write_t   fwd_mem;
    logic         ex_req;
    issue_t       ex_out;
    redirect_t    redir;
    logic         ex_ack;

    word_t       regs [32];
    reg_write_t  fx;
    reg_write_t  fm;
    logic [31:0] rng;
    int          issues_done;
    issue_t      exp_ex;
    redirect_t   exp_rd;
    logic        chk1;
    logic        chk2;

    always #10 clk = ~clk;

    dec_top dut_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_req_i (fetch_req),
        .fetch_i     (fetch_in),
        .fetch_ack_o (fetch_ack),
        .rf_rd_o     (rf_rd),
        .rf_data_i   (rf_data),
        .fwd_ex_i    (fwd_ex),
        .fwd_mem_i   (fwd_mem),
        .ex_req_o    (ex_req),
        .ex_o        (ex_out),
        .redirect_o  (redir),
        .ex_ack_i    (ex_ack)
    );

    // Register file read port with r0 held at zero in the table
    always_comb begin
        rf_data[0] = regs[rf_rd[0]];
        rf_data[1] = regs[rf_rd[1]];
    end

    function automatic logic [31:0] xorshift32();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic word_t pc_rand();
        return xorshift32() & 32'hffff_fffc;
    endfunction

    task automatic abort_run();
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [127:0] got, input logic [127:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s is %0h, expected %0h", $time, name, got, exp);
            abort_run();
        end
    endtask

    task automatic timed_out(input string what);
        $display("Timeout: %s did not happen within %0d cycles", what, TIMEOUT);
        abort_run();
    endtask

    // Execute forward first, then memory forward, then the register file
    function automatic word_t read_reg(input raddr_t a);
        if (fx.en && fx.addr == a) begin
            return fx.data;
        end
        if (fm.en && fm.addr == a) begin
            return fm.data;
        end
        return regs[a];
    endfunction

    task automatic fill_regs();
        regs[0] = '0;
        for (int i = 1; i < 32; i++) begin
            regs[i] = xorshift32();
        end
    endtask

    task automatic set_forwards(input reg_write_t ex, input reg_write_t mem);
        fx = ex;
        fm = mem;
        @(posedge clk);
        fwd_ex  <= ex;
        fwd_mem <= mem;
    endtask

    task automatic expect_issue(input logic [7:0] op, input logic [2:0] sel, input word_t s1,
                                input word_t s2, input logic wen, input raddr_t wa,
                                input word_t link);
        exp_ex.aluop     = op;
        exp_ex.alusel    = sel;
        exp_ex.src1      = s1;
        exp_ex.src2      = s2;
        exp_ex.wr_en     = wen;
        exp_ex.wr_addr   = wa;
        exp_ex.link_data = link;
        exp_rd           = '0;
        chk1             = 1'b1;
        chk2             = 1'b1;
    endtask

    task automatic send_fetch(input fetch_t f, input int min_done);
        int n;
        @(posedge clk);
        fetch_req <= 1'b1;
        fetch_in  <= f;
        n = 0;
        @(negedge clk);
        while (!fetch_ack) begin
            n++;
            if (n > TIMEOUT) begin
                timed_out("fetch_ack_o rising");
            end
            @(negedge clk);
        end
        if (min_done > 0) begin
            check("issues_done at fetch_ack_o", issues_done >= min_done, 1'b1);
        end
        @(posedge clk);
        fetch_req <= 1'b0;
        n = 0;
        @(negedge clk);
        while (fetch_ack) begin
            n++;
            if (n > TIMEOUT) begin
                timed_out("fetch_ack_o falling");
            end
            @(negedge clk);
        end
    endtask

    task automatic sink_ex(input int hold, output issue_t ex, output redirect_t rd);
        int n;
        n = 0;
        @(negedge clk);
        while (!ex_req) begin
            n++;
            if (n > TIMEOUT) begin
                timed_out("ex_req_o rising");
            end
            @(negedge clk);
        end
        ex = ex_out;
        rd = redir;
        if (hold > 0) begin
            repeat (hold) @(negedge clk);
            // Bundle held while execute stalls
            check("ex_req_o", ex_req, 1'b1);
            check("ex_o", ex_out, ex);
            check("redirect_o", redir, rd);
        end
        @(posedge clk);
        ex_ack <= 1'b1;
        n = 0;
        @(negedge clk);
        while (ex_req) begin
            n++;
            if (n > TIMEOUT) begin
                timed_out("ex_req_o falling");
            end
            @(negedge clk);
        end
        @(posedge clk);
        ex_ack <= 1'b0;
        issues_done++;
    endtask

    task automatic compare_issue(input issue_t got, input redirect_t got_rd, input issue_t e,
                                 input redirect_t e_rd, input logic c1, input logic c2);
        check("ex_o.aluop", got.aluop, e.aluop);
        check("ex_o.alusel", got.alusel, e.alusel);
        if (c1) begin
            check("ex_o.src1", got.src1, e.src1);
        end
        if (c2) begin
            check("ex_o.src2", got.src2, e.src2);
        end
        check("ex_o.wr_en", got.wr_en, e.wr_en);
        if (e.wr_en) begin
            check("ex_o.wr_addr", got.wr_addr, e.wr_addr);
        end
        check("ex_o.link_data", got.link_data, e.link_data);
        check("redirect_o.taken", got_rd.taken, e_rd.taken);
        if (e_rd.taken) begin
            check("redirect_o.target", got_rd.target, e_rd.target);
        end
    endtask

    task automatic run_inst(input logic [31:0] w, input word_t pc);
        fetch_t    f;
        issue_t    got;
        redirect_t got_rd;
        f.inst = w;
        f.pc   = pc;
        fork
            send_fetch(f, 0);
            sink_ex(0, got, got_rd);
        join
        compare_issue(got, got_rd, exp_ex, exp_rd, chk1, chk2);
    endtask

    task automatic reset_and_latency();
        fetch_t    f;
        issue_t    got;
        redirect_t got_rd;
        @(negedge clk);
        check("fetch_ack_o", fetch_ack, 1'b0);
        check("ex_req_o", ex_req, 1'b0);
        check("redirect_o.taken", redir.taken, 1'b0);
        f.pc   = 32'h0000_1000;
        f.inst = {`OP_ADDW, 5'd3, 5'd2, 5'd4};
        expect_issue(`ALU_ADDW, `ALU_SEL_ARITHMETIC, read_reg(5'd2), read_reg(5'd3), 1'b1,
                     5'd4, '0);
        fork
            send_fetch(f, 0);
            begin
                // Both rise on the second edge after req is driven
                @(posedge clk);
                repeat (2) begin
                    @(negedge clk);
                    check("fetch_ack_o", fetch_ack, 1'b0);
                    check("ex_req_o", ex_req, 1'b0);
                end
                @(negedge clk);
                check("fetch_ack_o", fetch_ack, 1'b1);
                check("ex_req_o", ex_req, 1'b1);
                sink_ex(0, got, got_rd);
            end
        join
        compare_issue(got, got_rd, exp_ex, exp_rd, 1'b1, 1'b1);
    endtask

    task automatic reg_reg_ops();
        logic [16:0] ops  [11];
        logic [7:0]  alus [11];
        logic [2:0]  sels [11];
        logic [31:0] r;
        ops  = '{`OP_ADDW, `OP_SUBW, `OP_SLT, `OP_SLTU, `OP_NOR, `OP_AND, `OP_OR, `OP_XOR,
                 `OP_SLLW, `OP_SRLW, `OP_SRAW};
        alus = '{`ALU_ADDW, `ALU_SUBW, `ALU_SLT, `ALU_SLTU, `ALU_NOR, `ALU_AND, `ALU_OR,
                 `ALU_XOR, `ALU_SLLW, `ALU_SRLW, `ALU_SRAW};
        sels = '{`ALU_SEL_ARITHMETIC, `ALU_SEL_ARITHMETIC, `ALU_SEL_ARITHMETIC,
                 `ALU_SEL_ARITHMETIC, `ALU_SEL_LOGIC, `ALU_SEL_LOGIC, `ALU_SEL_LOGIC,
                 `ALU_SEL_LOGIC, `ALU_SEL_SHIFT, `ALU_SEL_SHIFT, `ALU_SEL_SHIFT};
        for (int i = 0; i < 11; i++) begin
            fill_regs();
            r = xorshift32();
            expect_issue(alus[i], sels[i], read_reg(r[4:0]), read_reg(r[9:5]), 1'b1,
                         r[14:10], '0);
            run_inst({ops[i], r[9:5], r[4:0], r[14:10]}, pc_rand());
        end
    endtask

    task automatic imm_ops();
        logic [9:0]  iops  [6];
        logic [7:0]  ialus [6];
        logic [16:0] sops  [3];
        logic [7:0]  salus [3];
        logic [31:0] r;
        word_t       imm;
        word_t       pc;
        iops  = '{`OP_SLTI, `OP_SLTUI, `OP_ADDIW, `OP_ANDI, `OP_ORI, `OP_XORI};
        ialus = '{`ALU_SLTI, `ALU_SLTUI, `ALU_ADDIW, `ALU_ANDI, `ALU_ORI, `ALU_XORI};
        sops  = '{`OP_SLLIW, `OP_SRLIW, `OP_SRAIW};
        salus = '{`ALU_SLLIW, `ALU_SRLIW, `ALU_SRAIW};
        fill_regs();
        for (int i = 0; i < 6; i++) begin
            r = xorshift32();
            // First three sign-extend and the logic group zero-extends
            imm = (i < 3) ? {{20{r[21]}}, r[21:10]} : {20'b0, r[21:10]};
            expect_issue(ialus[i], (i < 3) ? `ALU_SEL_ARITHMETIC : `ALU_SEL_LOGIC,
                         read_reg(r[4:0]), imm, 1'b1, r[9:5], '0);
            run_inst({iops[i], r[21:10], r[4:0], r[9:5]}, pc_rand());
        end
        for (int i = 0; i < 3; i++) begin
            r = xorshift32();
            expect_issue(salus[i], `ALU_SEL_SHIFT, read_reg(r[4:0]), {27'b0, r[14:10]}, 1'b1,
                         r[9:5], '0);
            run_inst({sops[i], r[14:10], r[4:0], r[9:5]}, pc_rand());
        end
        r = xorshift32();
        expect_issue(`ALU_LU12I, `ALU_SEL_LOGIC, '0, {r[24:5], 12'b0}, 1'b1, r[4:0], '0);
        run_inst({`OP_LU12I, r[24:5], r[4:0]}, pc_rand());
        r  = xorshift32();
        pc = pc_rand();
        expect_issue(`ALU_PCADDU12I, `ALU_SEL_ARITHMETIC, pc, {r[24:5], 12'b0}, 1'b1, r[4:0],
                     '0);
        run_inst({`OP_PCADDU12I, r[24:5], r[4:0]}, pc);
    endtask

    task automatic forwarding_priority();
        raddr_t rj;
        raddr_t rk;
        rj = 5'd5;
        rk = 5'd9;
        fill_regs();
        for (int i = 0; i < 4; i++) begin
            case (i)
                0: set_forwards({1'b1, rj, xorshift32()}, {1'b1, rj, xorshift32()});
                1: set_forwards({1'b1, rk, xorshift32()}, {1'b1, rj, xorshift32()});
                2: set_forwards({1'b0, rj, xorshift32()}, {1'b1, rk, xorshift32()});
                default: set_forwards({1'b1, rk, xorshift32()}, {1'b1, rk, xorshift32()});
            endcase
            expect_issue(`ALU_ADDW, `ALU_SEL_ARITHMETIC, read_reg(rj), read_reg(rk), 1'b1,
                         5'd12, '0);
            run_inst({`OP_ADDW, rk, rj, 5'd12}, pc_rand());
        end
        set_forwards('0, '0);
    endtask

    task automatic branch_ops();
        logic [5:0]  bops  [6];
        logic [7:0]  balus [6];
        logic [31:0] r;
        raddr_t      rd;
        word_t       a;
        word_t       b;
        word_t       pc;
        logic        tk;
        bops  = '{`OP_BEQ, `OP_BNE, `OP_BLT, `OP_BGE, `OP_BLTU, `OP_BGEU};
        balus = '{`ALU_BEQ, `ALU_BNE, `ALU_BLT, `ALU_BGE, `ALU_BLTU, `ALU_BGEU};
        for (int k = 0; k < 6; k++) begin
            for (int n = 0; n < 4; n++) begin
                fill_regs();
                r  = xorshift32();
                rd = (n == 0) ? r[4:0] : r[9:5];
                a  = read_reg(r[4:0]);
                b  = read_reg(rd);
                case (k)
                    0: tk = a == b;
                    1: tk = a != b;
                    2: tk = $signed(a) < $signed(b);
                    3: tk = $signed(a) >= $signed(b);
                    4: tk = a < b;
                    default: tk = a >= b;
                endcase
                pc = pc_rand();
                expect_issue(balus[k], `ALU_SEL_JUMP_BRANCH, a, b, 1'b0, rd, '0);
                exp_rd.taken  = tk;
                exp_rd.target = pc + {{14{r[25]}}, r[25:10], 2'b00};
                run_inst({bops[k], r[25:10], r[4:0], rd}, pc);
            end
        end
        for (int n = 0; n < 3; n++) begin
            fill_regs();
            r  = xorshift32();
            pc = pc_rand();
            expect_issue(`ALU_B, `ALU_SEL_JUMP_BRANCH, '0, '0, 1'b0, '0, '0);
            chk1   = 1'b0;
            chk2   = 1'b0;
            exp_rd = {1'b1, pc + {{4{r[9]}}, r[9:0], r[25:10], 2'b00}};
            run_inst({`OP_B, r[25:10], r[9:0]}, pc);
            expect_issue(`ALU_BL, `ALU_SEL_JUMP_BRANCH, '0, '0, 1'b1, 5'd1, pc + 32'd4);
            chk1   = 1'b0;
            chk2   = 1'b0;
            exp_rd = {1'b1, pc + {{4{r[9]}}, r[9:0], r[25:10], 2'b00}};
            run_inst({`OP_BL, r[25:10], r[9:0]}, pc);
            a = read_reg(r[4:0]);
            expect_issue(`ALU_JIRL, `ALU_SEL_JUMP_BRANCH, a, '0, 1'b1, r[9:5], pc + 32'd4);
            chk2   = 1'b0;
            exp_rd = {1'b1, a + {{14{r[25]}}, r[25:10], 2'b00}};
            run_inst({`OP_JIRL, r[25:10], r[4:0], r[9:5]}, pc);
        end
    endtask

    task automatic backpressure_order();
        fetch_t    f1;
        fetch_t    f2;
        issue_t    e1;
        issue_t    e2;
        issue_t    g1;
        issue_t    g2;
        redirect_t r1;
        redirect_t r2;
        redirect_t h1;
        redirect_t h2;
        int        hold;
        fill_regs();
        f1.pc   = pc_rand();
        f1.inst = {`OP_ADDW, 5'd7, 5'd6, 5'd8};
        expect_issue(`ALU_ADDW, `ALU_SEL_ARITHMETIC, read_reg(5'd6), read_reg(5'd7), 1'b1,
                     5'd8, '0);
        e1 = exp_ex;
        r1 = exp_rd;
        f2.pc   = f1.pc + 32'd4;
        f2.inst = {`OP_ORI, 12'hf3c, 5'd10, 5'd11};
        expect_issue(`ALU_ORI, `ALU_SEL_LOGIC, read_reg(5'd10), 32'h0000_0f3c, 1'b1, 5'd11,
                     '0);
        e2 = exp_ex;
        r2 = exp_rd;
        hold = 4 + xorshift32() % 12;
        issues_done = 0;
        fork
            begin
                send_fetch(f1, 0);
                send_fetch(f2, 1);
            end
            begin
                sink_ex(hold, g1, h1);
                sink_ex(xorshift32() % 4, g2, h2);
            end
        join
        compare_issue(g1, h1, e1, r1, 1'b1, 1'b1);
        compare_issue(g2, h2, e2, r2, 1'b1, 1'b1);
    endtask

    initial begin
        clk         = 1'b0;
        rst         = 1'b1;
        fetch_req   = 1'b0;
        fetch_in    = '0;
        fwd_ex      = '0;
        fwd_mem     = '0;
        ex_ack      = 1'b0;
        fx          = '0;
        fm          = '0;
        rng         = 32'hb853_2fc9;
        issues_done = 0;
        fill_regs();
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        reset_and_latency();
        reg_reg_ops();
        imm_ops();
        forwarding_priority();
        branch_ops();
        backpressure_order();
        $display("NO ERRORS");
        $finish;
    end

endmodule

/* include/dec_consts.svh */
`ifndef DEC_CONSTS_SVH
`define DEC_CONSTS_SVH

`define DEC_XLEN     32
`define DEC_RADDR_W  5
`define DEC_ALUOP_W  8
`define DEC_ALUSEL_W 3
`define DEC_LINK_REG 5'd1

// 3R group and shift immediates, inst[31:15]
`define OP_ADDW      17'h00020
`define OP_SUBW      17'h00022
`define OP_SLT       17'h00024
`define OP_SLTU      17'h00025
`define OP_NOR       17'h00028
`define OP_AND       17'h00029
`define OP_OR        17'h0002a
`define OP_XOR       17'h0002b
`define OP_SLLW      17'h0002e
`define OP_SRLW      17'h0002f
`define OP_SRAW      17'h00030
`define OP_SLLIW     17'h00081
`define OP_SRLIW     17'h00089
`define OP_SRAIW     17'h00091

// 2RI12 group, inst[31:22]
`define OP_SLTI      10'h008
`define OP_SLTUI     10'h009
`define OP_ADDIW     10'h00a
`define OP_ANDI      10'h00d
`define OP_ORI       10'h00e
`define OP_XORI      10'h00f

// 1RI20 group, inst[31:25]
`define OP_LU12I     7'h0a
`define OP_PCADDU12I 7'h0e

// Jumps and branches, inst[31:26]
`define OP_JIRL      6'h13
`define OP_B         6'h14
`define OP_BL        6'h15
`define OP_BEQ       6'h16
`define OP_BNE       6'h17
`define OP_BLT       6'h18
`define OP_BGE       6'h19
`define OP_BLTU      6'h1a
`define OP_BGEU      6'h1b

`define ALU_SEL_NOP         3'd0
`define ALU_SEL_LOGIC       3'd1
`define ALU_SEL_SHIFT       3'd2
`define ALU_SEL_ARITHMETIC  3'd3
`define ALU_SEL_JUMP_BRANCH 3'd4

`define ALU_NOP       8'h00
`define ALU_ADDW      8'h01
`define ALU_SUBW      8'h02
`define ALU_SLT       8'h03
`define ALU_SLTU      8'h04
`define ALU_NOR       8'h05
`define ALU_AND       8'h06
`define ALU_OR        8'h07
`define ALU_XOR       8'h08
`define ALU_SLLW      8'h09
`define ALU_SRLW      8'h0a
`define ALU_SRAW      8'h0b
`define ALU_SLTI      8'h0c
`define ALU_SLTUI     8'h0d
`define ALU_ADDIW     8'h0e
`define ALU_ANDI      8'h0f
`define ALU_ORI       8'h10
`define ALU_XORI      8'h11
`define ALU_SLLIW     8'h12
`define ALU_SRLIW     8'h13
`define ALU_SRAIW     8'h14
`define ALU_LU12I     8'h15
`define ALU_PCADDU12I 8'h16
`define ALU_BEQ       8'h17
`define ALU_BNE       8'h18
`define ALU_BLT       8'h19
`define ALU_BGE       8'h1a
`define ALU_BLTU      8'h1b
`define ALU_BGEU      8'h1c
`define ALU_B         8'h1d
`define ALU_BL        8'h1e
`define ALU_JIRL      8'h1f

// Branch kinds
`define BR_NONE 4'd0
`define BR_EQ   4'd1
`define BR_NE   4'd2
`define BR_LT   4'd3
`define BR_GE   4'd4
`define BR_LTU  4'd5
`define BR_GEU  4'd6
`define BR_B    4'd7
`define BR_BL   4'd8
`define BR_JIRL 4'd9

// Issue handshake states
`define ISS_IDLE    2'd0
`define ISS_WAIT_HI 2'd1
`define ISS_WAIT_LO 2'd2

`endif

/* source/branch_unit.sv */
`timescale 1ns/1ns
`include "dec_consts.svh"

module branch_unit import dec_pkg::*; (
    input  ctrl_t     ctrl_i,
    input  fetch_t    slot_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    output redirect_t redirect_o,
    output word_t     link_data_o
);

    inst_u inst;
    word_t off16;
    word_t off26;
    logic  eq;
    logic  lt;
    logic  ltu;
    logic  taken;

    assign inst  = slot_i.inst;
    assign off16 = {{14{inst.fmt_br16.offs16[15]}}, inst.fmt_br16.offs16, 2'b00};
    // B and BL spread the offset over rj, rd and offs16
    assign off26 = {{4{inst.fmt_br16.rj[4]}}, inst.fmt_br16.rj, inst.fmt_br16.rd,
                    inst.fmt_br16.offs16, 2'b00};

    assign eq  = src1_i == src2_i;
    assign lt  = $signed(src1_i) < $signed(src2_i);
    assign ltu = src1_i < src2_i;

    always_comb begin
        case (ctrl_i.br_kind)
            `BR_EQ:  taken = eq;
            `BR_NE:  taken = !eq;
            `BR_LT:  taken = lt;
            `BR_GE:  taken = !lt;
            `BR_LTU: taken = ltu;
            `BR_GEU: taken = !ltu;
            `BR_B, `BR_BL, `BR_JIRL: taken = 1'b1;
            default: taken = 1'b0;
        endcase
        redirect_o.taken  = taken;
        redirect_o.target = '0;
        if (taken) begin
            case (ctrl_i.br_kind)
                `BR_B, `BR_BL: redirect_o.target = slot_i.pc + off26;
                `BR_JIRL:      redirect_o.target = src1_i + off16;
                default:       redirect_o.target = slot_i.pc + off16;
            endcase
        end
    end

    assign link_data_o = (ctrl_i.br_kind == `BR_BL || ctrl_i.br_kind == `BR_JIRL) ?
                         slot_i.pc + 32'd4 : '0;

endmodule

/* source/dec_pkg.sv */
package dec_pkg;

`include "dec_consts.svh"

    typedef logic [`DEC_XLEN-1:0]    word_t;
    typedef logic [`DEC_RADDR_W-1:0] raddr_t;
    typedef logic [3:0]              br_kind_t;

    // Same 32-bit word under the four encodings
    typedef union packed {
        struct packed {
            logic [16:0] opcode17;
            raddr_t      rk;
            raddr_t      rj;
            raddr_t      rd;
        } fmt_3r;
        struct packed {
            logic [9:0]  opcode10;
            logic [11:0] imm12;
            raddr_t      rj;
            raddr_t      rd;
        } fmt_2ri12;
        struct packed {
            logic [6:0]  opcode7;
            logic [19:0] imm20;
            raddr_t      rd;
        } fmt_1ri20;
        struct packed {
            logic [5:0]  opcode6;
            logic [15:0] offs16;
            raddr_t      rj;
            raddr_t      rd;
        } fmt_br16;
    } inst_u;

    typedef struct packed {
        inst_u inst;
        word_t pc;
    } fetch_t;

    // One write seen in a later stage
    typedef struct packed {
        logic   en;
        raddr_t addr;
        word_t  data;
    } reg_write_t;

    typedef struct packed {
        logic [`DEC_ALUOP_W-1:0]  aluop;
        logic [`DEC_ALUSEL_W-1:0] alusel;
        logic                     wr_en;
        raddr_t                   wr_addr;
        logic                     rd1_en;
        logic                     rd2_en;
        raddr_t                   rd1_addr;
        raddr_t                   rd2_addr;
        logic                     use_pc1;
        word_t                    imm;
        br_kind_t                 br_kind;
    } ctrl_t;

    typedef struct packed {
        logic [`DEC_ALUOP_W-1:0]  aluop;
        logic [`DEC_ALUSEL_W-1:0] alusel;
        word_t                    src1;
        word_t                    src2;
        logic                     wr_en;
        raddr_t                   wr_addr;
        word_t                    link_data;
    } issue_t;

    typedef struct packed {
        logic  taken;
        word_t target;
    } redirect_t;

endpackage

/* source/dec_top.sv */
`timescale 1ns/1ns

module dec_top import dec_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  logic         fetch_req_i,
    input  fetch_t       fetch_i,
    output logic         fetch_ack_o,
    output raddr_t [1:0] rf_rd_o,
    input  word_t  [1:0] rf_data_i,
    input  reg_write_t   fwd_ex_i,
    input  reg_write_t   fwd_mem_i,
    output logic         ex_req_o,
    output issue_t       ex_o,
    output redirect_t    redirect_o,
    input  logic         ex_ack_i
);

    logic      slot_full;
    logic      take;
    fetch_t    slot;
    ctrl_t     ctrl;
    word_t     src1;
    word_t     src2;
    word_t     link_data;
    redirect_t redirect;

    assign rf_rd_o[0] = ctrl.rd1_addr;
    assign rf_rd_o[1] = ctrl.rd2_addr;

    fetch_port fetch_port_i (
        .clk         (clk),
        .rst         (rst),
        .fetch_req_i (fetch_req_i),
        .fetch_i     (fetch_i),
        .fetch_ack_o (fetch_ack_o),
        .take_i      (take),
        .slot_full_o (slot_full),
        .slot_o      (slot)
    );

    inst_decoder inst_decoder_i (
        .slot_i (slot),
        .ctrl_o (ctrl)
    );

    operand_select operand_select_i (
        .ctrl_i    (ctrl),
        .pc_i      (slot.pc),
        .rf_data_i (rf_data_i),
        .fwd_ex_i  (fwd_ex_i),
        .fwd_mem_i (fwd_mem_i),
        .src1_o    (src1),
        .src2_o    (src2)
    );

    branch_unit branch_unit_i (
        .ctrl_i      (ctrl),
        .slot_i      (slot),
        .src1_i      (src1),
        .src2_i      (src2),
        .redirect_o  (redirect),
        .link_data_o (link_data)
    );

    issue_port issue_port_i (
        .clk         (clk),
        .rst         (rst),
        .slot_full_i (slot_full),
        .ctrl_i      (ctrl),
        .src1_i      (src1),
        .src2_i      (src2),
        .link_data_i (link_data),
        .redirect_i  (redirect),
        .take_o      (take),
        .ex_req_o    (ex_req_o),
        .ex_o        (ex_o),
        .redirect_o  (redirect_o),
        .ex_ack_i    (ex_ack_i)
    );

endmodule

/* source/fetch_port.sv */
`timescale 1ns/1ns

module fetch_port import dec_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   fetch_req_i,
    input  fetch_t fetch_i,
    output logic   fetch_ack_o,
    input  logic   take_i,
    output logic   slot_full_o,
    output fetch_t slot_o
);

    logic capture;

    // Previous handshake must be closed and the slot free
    assign capture = fetch_req_i && !fetch_ack_o && !slot_full_o;

    always_ff @(posedge clk) begin
        if (capture) begin
            slot_o <= fetch_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_full_o <= 1'b0;
            fetch_ack_o <= 1'b0;
        end else begin
            if (capture) begin
                slot_full_o <= 1'b1;
            end else if (take_i) begin
                slot_full_o <= 1'b0;
            end
            // Ack only once the word has moved on to issue
            if (take_i) begin
                fetch_ack_o <= 1'b1;
            end else if (!fetch_req_i) begin
                fetch_ack_o <= 1'b0;
            end
        end
    end

    assert property (@(posedge clk) disable iff (rst)
        (fetch_req_i && !fetch_ack_o) ##1 (fetch_req_i && !fetch_ack_o) |-> $stable(fetch_i));

    assert property (@(posedge clk) disable iff (rst) take_i |-> slot_full_o);

endmodule

/* source/inst_decoder.sv */
`timescale 1ns/1ns
`include "dec_consts.svh"

module inst_decoder import dec_pkg::*; (
    input  fetch_t slot_i,
    output ctrl_t  ctrl_o
);

    inst_u                    inst;
    logic [`DEC_ALUOP_W-1:0]  op;
    logic [`DEC_ALUSEL_W-1:0] sel;
    br_kind_t                 kind;
    logic                     rr;
    logic                     ri5;
    logic                     sx12;
    logic                     zx12;
    logic                     hi20;
    logic                     pc1;
    logic                     cb;
    logic                     one_src;

    assign inst = slot_i.inst;

    always_comb begin
        op   = `ALU_NOP;
        sel  = `ALU_SEL_NOP;
        kind = `BR_NONE;
        {rr, ri5, sx12, zx12, hi20, pc1, cb} = 7'b0;

        case (inst.fmt_3r.opcode17)
            `OP_ADDW:  {op, sel, rr} = {`ALU_ADDW, `ALU_SEL_ARITHMETIC, 1'b1};
            `OP_SUBW:  {op, sel, rr} = {`ALU_SUBW, `ALU_SEL_ARITHMETIC, 1'b1};
            `OP_SLT:   {op, sel, rr} = {`ALU_SLT, `ALU_SEL_ARITHMETIC, 1'b1};
            `OP_SLTU:  {op, sel, rr} = {`ALU_SLTU, `ALU_SEL_ARITHMETIC, 1'b1};
            `OP_NOR:   {op, sel, rr} = {`ALU_NOR, `ALU_SEL_LOGIC, 1'b1};
            `OP_AND:   {op, sel, rr} = {`ALU_AND, `ALU_SEL_LOGIC, 1'b1};
            `OP_OR:    {op, sel, rr} = {`ALU_OR, `ALU_SEL_LOGIC, 1'b1};
            `OP_XOR:   {op, sel, rr} = {`ALU_XOR, `ALU_SEL_LOGIC, 1'b1};
            `OP_SLLW:  {op, sel, rr} = {`ALU_SLLW, `ALU_SEL_SHIFT, 1'b1};
            `OP_SRLW:  {op, sel, rr} = {`ALU_SRLW, `ALU_SEL_SHIFT, 1'b1};
            `OP_SRAW:  {op, sel, rr} = {`ALU_SRAW, `ALU_SEL_SHIFT, 1'b1};
            `OP_SLLIW: {op, sel, ri5} = {`ALU_SLLIW, `ALU_SEL_SHIFT, 1'b1};
            `OP_SRLIW: {op, sel, ri5} = {`ALU_SRLIW, `ALU_SEL_SHIFT, 1'b1};
            `OP_SRAIW: {op, sel, ri5} = {`ALU_SRAIW, `ALU_SEL_SHIFT, 1'b1};
            default: ;
        endcase

        case (inst.fmt_2ri12.opcode10)
            `OP_SLTI:  {op, sel, sx12} = {`ALU_SLTI, `ALU_SEL_ARITHMETIC, 1'b1};
            `OP_SLTUI: {op, sel, sx12} = {`ALU_SLTUI, `ALU_SEL_ARITHMETIC, 1'b1};
            `OP_ADDIW: {op, sel, sx12} = {`ALU_ADDIW, `ALU_SEL_ARITHMETIC, 1'b1};
            `OP_ANDI:  {op, sel, zx12} = {`ALU_ANDI, `ALU_SEL_LOGIC, 1'b1};
            `OP_ORI:   {op, sel, zx12} = {`ALU_ORI, `ALU_SEL_LOGIC, 1'b1};
            `OP_XORI:  {op, sel, zx12} = {`ALU_XORI, `ALU_SEL_LOGIC, 1'b1};
            default: ;
        endcase

        case (inst.fmt_1ri20.opcode7)
            `OP_LU12I:     {op, sel, hi20} = {`ALU_LU12I, `ALU_SEL_LOGIC, 1'b1};
            `OP_PCADDU12I: {op, sel, hi20, pc1} = {`ALU_PCADDU12I, `ALU_SEL_ARITHMETIC, 2'b11};
            default: ;
        endcase

        case (inst.fmt_br16.opcode6)
            `OP_BEQ:  {op, kind, cb} = {`ALU_BEQ, `BR_EQ, 1'b1};
            `OP_BNE:  {op, kind, cb} = {`ALU_BNE, `BR_NE, 1'b1};
            `OP_BLT:  {op, kind, cb} = {`ALU_BLT, `BR_LT, 1'b1};
            `OP_BGE:  {op, kind, cb} = {`ALU_BGE, `BR_GE, 1'b1};
            `OP_BLTU: {op, kind, cb} = {`ALU_BLTU, `BR_LTU, 1'b1};
            `OP_BGEU: {op, kind, cb} = {`ALU_BGEU, `BR_GEU, 1'b1};
            `OP_B:    {op, kind} = {`ALU_B, `BR_B};
            `OP_BL:   {op, kind} = {`ALU_BL, `BR_BL};
            `OP_JIRL: {op, kind} = {`ALU_JIRL, `BR_JIRL};
            default: ;
        endcase
    end

    // rj plus an immediate
    assign one_src = ri5 || sx12 || zx12 || hi20;

    always_comb begin
        ctrl_o.aluop    = op;
        ctrl_o.alusel   = (kind == `BR_NONE) ? sel : `ALU_SEL_JUMP_BRANCH;
        ctrl_o.br_kind  = kind;
        ctrl_o.use_pc1  = pc1;
        ctrl_o.wr_en    = rr || one_src || kind == `BR_BL || kind == `BR_JIRL;
        ctrl_o.wr_addr  = (kind == `BR_BL) ? `DEC_LINK_REG : inst.fmt_3r.rd;
        ctrl_o.rd1_en   = rr || one_src || cb || kind == `BR_JIRL;
        ctrl_o.rd2_en   = rr || cb;
        // LU12I adds to r0
        ctrl_o.rd1_addr = hi20 ? '0 : inst.fmt_3r.rj;
        ctrl_o.rd2_addr = cb ? inst.fmt_br16.rd : inst.fmt_3r.rk;
        if (sx12) begin
            ctrl_o.imm = {{20{inst.fmt_2ri12.imm12[11]}}, inst.fmt_2ri12.imm12};
        end else if (zx12) begin
            ctrl_o.imm = {20'b0, inst.fmt_2ri12.imm12};
        end else if (hi20) begin
            ctrl_o.imm = {inst.fmt_1ri20.imm20, 12'b0};
        end else begin
            ctrl_o.imm = {27'b0, inst.fmt_3r.rk};
        end
    end

endmodule

/* source/issue_port.sv */
`timescale 1ns/1ns
`include "dec_consts.svh"

module issue_port import dec_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      slot_full_i,
    input  ctrl_t     ctrl_i,
    input  word_t     src1_i,
    input  word_t     src2_i,
    input  word_t     link_data_i,
    input  redirect_t redirect_i,
    output logic      take_o,
    output logic      ex_req_o,
    output issue_t    ex_o,
    output redirect_t redirect_o,
    input  logic      ex_ack_i
);

    logic [1:0] state;

    assign take_o   = slot_full_i && state == `ISS_IDLE;
    assign ex_req_o = state == `ISS_WAIT_HI;

    always_ff @(posedge clk) begin
        if (rst) begin
            state            <= `ISS_IDLE;
            redirect_o.taken <= 1'b0;
        end else begin
            case (state)
                `ISS_IDLE: begin
                    if (take_o) begin
                        state      <= `ISS_WAIT_HI;
                        redirect_o <= redirect_i;
                    end
                end
                `ISS_WAIT_HI: begin
                    if (ex_ack_i) begin
                        state <= `ISS_WAIT_LO;
                    end
                end
                // Sink has to release ack before the next request
                `ISS_WAIT_LO: begin
                    if (!ex_ack_i) begin
                        state <= `ISS_IDLE;
                    end
                end
                default: state <= `ISS_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_o) begin
            ex_o.aluop     <= ctrl_i.aluop;
            ex_o.alusel    <= ctrl_i.alusel;
            ex_o.src1      <= src1_i;
            ex_o.src2      <= src2_i;
            ex_o.wr_en     <= ctrl_i.wr_en;
            ex_o.wr_addr   <= ctrl_i.wr_addr;
            ex_o.link_data <= link_data_i;
        end
    end

    // Execute may raise ack only against a pending request
    assert property (@(posedge clk) disable iff (rst) $rose(ex_ack_i) |-> ex_req_o);

endmodule

/* source/operand_select.sv */
`timescale 1ns/1ns

module operand_select import dec_pkg::*; (
    input  ctrl_t       ctrl_i,
    input  word_t       pc_i,
    input  word_t [1:0] rf_data_i,
    input  reg_write_t  fwd_ex_i,
    input  reg_write_t  fwd_mem_i,
    output word_t       src1_o,
    output word_t       src2_o
);

    // Execute wins over memory, memory over the register file
    function automatic word_t pick(input logic en, input raddr_t addr, input word_t rf,
                                   input word_t imm, input reg_write_t ex,
                                   input reg_write_t mem);
        if (!en) begin
            return imm;
        end
        if (ex.en && ex.addr == addr) begin
            return ex.data;
        end
        if (mem.en && mem.addr == addr) begin
            return mem.data;
        end
        return rf;
    endfunction

    always_comb begin
        if (ctrl_i.use_pc1) begin
            src1_o = pc_i;
        end else begin
            src1_o = pick(ctrl_i.rd1_en, ctrl_i.rd1_addr, rf_data_i[0], ctrl_i.imm,
                          fwd_ex_i, fwd_mem_i);
        end
        src2_o = pick(ctrl_i.rd2_en, ctrl_i.rd2_addr, rf_data_i[1], ctrl_i.imm,
                      fwd_ex_i, fwd_mem_i);
    end

endmodule
